/* include/eeprom_defs.svh */
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// byte address of a 2048-byte part
`define EE_ADDR_W   11

`define EE_DATA_W   8

// upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

// CLK cycles per SCL bit
`define EE_PHASES   4

`endif

/* verilog/eeprom_pkg.sv */
`include "eeprom_defs.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_data_t;
    typedef logic [`EE_ADDR_W-`EE_DATA_W-1:0] ee_block_t;  // carried in the control byte

    typedef enum logic [1:0] {
        CMD_START,
        CMD_WRITE,
        CMD_READ,
        CMD_STOP
    } byte_cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR_WR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE
    } ctrl_state_e;

    // byte engine states
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_SHIFT,
        ENG_ACK_BIT,
        ENG_FINISH
    } eng_state_e;

endpackage

/* verilog/i2c_byte_if.sv */
`timescale 1ns/1ps

interface i2c_byte_if;
    import eeprom_pkg::*;

    byte_cmd_e cmd;
    logic      go;
    ee_data_t  tx_byte;
    logic      last;     // master no-acknowledge on a read
    ee_data_t  rx_byte;
    logic      done;
    logic      nack;     // valid with done

    // transaction sequencer side
    modport seq (
        output cmd, go, tx_byte, last,
        input  rx_byte, done, nack
    );

    // byte engine side
    modport eng (
        input  cmd, go, tx_byte, last,
        output rx_byte, done, nack
    );

endinterface

/* verilog/i2c_byte_engine.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module i2c_byte_engine (
    input  logic    CLK,
    input  logic    RESET,
    output logic    scl,
    inout  wire     sda,
    i2c_byte_if.eng bus
);
    import eeprom_pkg::*;

    localparam int              PH_W      = $clog2(`EE_PHASES);
    localparam logic [PH_W-1:0] PH_LAST   = PH_W'(`EE_PHASES - 1);
    localparam logic [PH_W-1:0] PH_SAMPLE = PH_W'(`EE_PHASES - 2);
    localparam int              BYTE_CYC  = (`EE_DATA_W + 1) * `EE_PHASES;

    eng_state_e      state;
    logic [PH_W-1:0] phase;
    logic [2:0]      bit_cnt;
    byte_cmd_e       cmd_q;
    logic            last_q;
    ee_data_t        sh_q;
    ee_data_t        rx_q;
    logic            sda_low;
    logic            nack_q;
    logic            sda_in;
    logic            is_byte;

    assign sda     = sda_low ? 1'b0 : 1'bz;   // open drain
    assign sda_in  = sda;
    assign is_byte = (cmd_q == CMD_WRITE) || (cmd_q == CMD_READ);

    assign bus.rx_byte = rx_q;
    assign bus.nack    = nack_q;
    assign bus.done    = (state == ENG_FINISH);

    // {scl, sda pulled low} during one phase
    function automatic logic [1:0] wire_level(
        input byte_cmd_e       c,
        input logic            ack_bit,
        input logic [PH_W-1:0] p,
        input logic            tx_bit,
        input logic            lst
    );
        logic clk_hi;
        logic pull;
        clk_hi = (p != '0) && (p != PH_LAST);
        case (c)
            CMD_START:
                pull = (p >= PH_SAMPLE);        // sda falls in the high half
            CMD_STOP:
            begin
                clk_hi = (p != '0);
                pull   = (p < PH_SAMPLE);       // sda rises with scl high
            end
            CMD_WRITE:
                pull = ack_bit ? 1'b0 : !tx_bit;
            default:
                pull = ack_bit ? !lst : 1'b0;
        endcase
        return {clk_hi, pull};
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ENG_IDLE;
            phase   <= '0;
            bit_cnt <= '0;
            cmd_q   <= CMD_STOP;
            last_q  <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            nack_q  <= 1'b0;
        end
        else
        begin
            case (state)
                ENG_IDLE:
                    if (bus.go)
                    begin
                        cmd_q   <= bus.cmd;
                        last_q  <= bus.last;
                        nack_q  <= 1'b0;
                        phase   <= '0;
                        bit_cnt <= '0;
                        {scl, sda_low} <= wire_level(bus.cmd, 1'b0, '0,
                                                     bus.tx_byte[`EE_DATA_W-1], bus.last);
                        state   <= ENG_SHIFT;
                    end
                ENG_SHIFT:
                    if (phase != PH_LAST)
                    begin
                        phase <= phase + 1'b1;
                        {scl, sda_low} <= wire_level(cmd_q, 1'b0, phase + 1'b1,
                                                     sh_q[`EE_DATA_W-1], last_q);
                    end
                    else if (!is_byte)
                        state <= ENG_FINISH;    // start and stop take one bit time
                    else if (bit_cnt == 3'(`EE_DATA_W - 1))
                    begin
                        phase <= '0;
                        {scl, sda_low} <= wire_level(cmd_q, 1'b1, '0, 1'b0, last_q);
                        state <= ENG_ACK_BIT;
                    end
                    else
                    begin
                        phase   <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        {scl, sda_low} <= wire_level(cmd_q, 1'b0, '0,
                                                     sh_q[`EE_DATA_W-2], last_q);
                    end
                ENG_ACK_BIT:
                    if (phase != PH_LAST)
                    begin
                        if (phase == PH_SAMPLE && cmd_q == CMD_WRITE)
                            nack_q <= sda_in;   // released line means no slave ack
                        phase <= phase + 1'b1;
                        {scl, sda_low} <= wire_level(cmd_q, 1'b1, phase + 1'b1, 1'b0, last_q);
                    end
                    else
                        state <= ENG_FINISH;
                default:
                    state <= ENG_IDLE;
            endcase
        end
    end

    // byte shift registers
    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE && bus.go)
            sh_q <= bus.tx_byte;
        else if (state == ENG_SHIFT && phase == PH_LAST)
            sh_q <= {sh_q[`EE_DATA_W-2:0], 1'b0};
        if (state == ENG_SHIFT && phase == PH_SAMPLE && cmd_q == CMD_READ)
            rx_q <= {rx_q[`EE_DATA_W-2:0], sda_in};    // msb first
    end

    // data only moves while scl is low
    a_sda_stable: assert property (
        @(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(state != ENG_IDLE && !is_byte)) |-> $stable(sda)
    );

    // one done pulse per command, one cycle after its last phase
    a_done_pulse: assert property (
        @(posedge CLK) disable iff (RESET)
        (bus.go && (bus.cmd == CMD_START || bus.cmd == CMD_STOP))
            |=> !bus.done [*`EE_PHASES] ##1 bus.done ##1 !bus.done
    );

    a_done_byte: assert property (
        @(posedge CLK) disable iff (RESET)
        (bus.go && (bus.cmd == CMD_WRITE || bus.cmd == CMD_READ))
            |=> !bus.done [*BYTE_CYC] ##1 bus.done ##1 !bus.done
    );

endmodule

/* verilog/eeprom_ctrl.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_ctrl (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_data_t wr_data,
    output eeprom_pkg::ee_data_t rd_data,
    output logic                 ack,
    output logic                 err,
    output logic                 busy,
    i2c_byte_if.seq              bus
);
    import eeprom_pkg::*;

    ctrl_state_e state;
    ctrl_state_e nxt;
    ee_addr_t    addr_q;
    ee_data_t    data_q;
    ee_block_t   blk;
    logic        is_rd;
    logic        pend;      // command in flight on the engine
    logic        go_q;

    assign blk    = addr_q[`EE_ADDR_W-1:`EE_DATA_W];
    assign bus.go = go_q;

    // command held steady for the whole state
    always_comb
    begin
        bus.cmd     = CMD_WRITE;
        bus.tx_byte = data_q;
        bus.last    = 1'b0;
        case (state)
            START, RESTART:
                bus.cmd = CMD_START;
            CTRL_WR:
                bus.tx_byte = {`EE_DEV_CODE, blk, 1'b0};
            ADDR_WR:
                bus.tx_byte = addr_q[`EE_DATA_W-1:0];
            CTRL_RD:
                bus.tx_byte = {`EE_DEV_CODE, blk, 1'b1};
            DATA_RD:
            begin
                bus.cmd  = CMD_READ;
                bus.last = 1'b1;                 // single byte ends with master nack
            end
            STOP:
                bus.cmd = CMD_STOP;
            default:
                bus.cmd = CMD_WRITE;
        endcase
    end

    // state that follows a finished command
    always_comb
    begin
        case (state)
            START:   nxt = CTRL_WR;
            CTRL_WR: nxt = ADDR_WR;
            ADDR_WR: nxt = is_rd ? RESTART : DATA_WR;
            DATA_WR: nxt = STOP;
            RESTART: nxt = CTRL_RD;
            CTRL_RD: nxt = DATA_RD;
            DATA_RD: nxt = STOP;
            STOP:    nxt = DONE;
            default: nxt = IDLE;
        endcase
        if (bus.nack)
            nxt = STOP;     // abort through a stop that frees the bus
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            is_rd <= 1'b0;
            pend  <= 1'b0;
            go_q  <= 1'b0;
            ack   <= 1'b0;
            err   <= 1'b0;
            busy  <= 1'b0;
        end
        else
        begin
            go_q <= 1'b0;
            ack  <= 1'b0;
            case (state)
                IDLE:
                    if (wr || rd)
                    begin
                        is_rd <= !wr;                // write wins
                        err   <= 1'b0;
                        busy  <= 1'b1;
                        state <= START;
                    end
                DONE:
                begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default:
                    if (!pend)
                    begin
                        go_q <= 1'b1;
                        pend <= 1'b1;
                    end
                    else if (bus.done)
                    begin
                        pend  <= 1'b0;
                        state <= nxt;
                        if (bus.nack)
                            err <= 1'b1;
                    end
            endcase
        end
    end

    // request capture and read result
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (state == DONE && is_rd && !err)
            rd_data <= bus.rx_byte;       // engine keeps it through the stop
    end

    a_ack_busy: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |-> $past(busy)
    );

    // one command at a time on the engine
    a_one_cmd: assert property (
        @(posedge CLK) disable iff (RESET)
        bus.go |=> (!bus.go throughout bus.done[->1])
    );

endmodule

/* verilog/eeprom_master_top.sv */
`timescale 1ns/1ps

module eeprom_master_top (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_data_t wr_data,
    output eeprom_pkg::ee_data_t rd_data,
    output logic                 ack,
    output logic                 err,
    output logic                 busy,
    output logic                 scl,
    inout  wire                  sda
);

    i2c_byte_if bus_if ();

    // host request to byte commands
    eeprom_ctrl u_ctrl (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .err     (err),
        .busy    (busy),
        .bus     (bus_if.seq)
    );

    // bit timing on the two-wire bus
    i2c_byte_engine u_engine (
        .CLK   (CLK),
        .RESET (RESET),
        .scl   (scl),
        .sda   (sda),
        .bus   (bus_if.eng)
    );

endmodule

/* tb/eeprom_model.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic model_busy
);
    import eeprom_pkg::*;

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA} slave_state_e;

    ee_data_t     mem [0:(1 << `EE_ADDR_W)-1];
    slave_state_e state = M_IDLE;
    int           bit_cnt = 0;
    ee_data_t     sh;
    ee_block_t    blk;
    ee_data_t     word;          // byte pointer inside the block
    logic         rd_mode;
    logic         master_nack;
    logic         sda_low = 1'b0;

    assign sda = sda_low ? 1'b0 : 1'bz;

    function automatic ee_data_t fill_value(input ee_addr_t a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = fill_value(ee_addr_t'(i));
    end

    // start and stop move sda while scl is high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state   = M_CTRL;
            bit_cnt = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            state = M_IDLE;
    end

    always @(posedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (bit_cnt < `EE_DATA_W)
            begin
                if (state != M_RDATA)
                    sh = {sh[`EE_DATA_W-2:0], sda};
            end
            else
                master_nack = sda;    // ninth clock of a read byte
            bit_cnt++;
        end
    end

    always @(negedge scl)
    begin
        if (state != M_IDLE)
        begin
            if (bit_cnt == `EE_DATA_W)
            begin
                sda_low = 1'b1;
                case (state)
                    M_CTRL:
                        if (sh[7:4] != `EE_DEV_CODE || model_busy)
                        begin
                            sda_low = 1'b0;    // no ack until the next start
                            state   = M_IDLE;
                        end
                        else
                        begin
                            blk     = sh[3:1];
                            rd_mode = sh[0];
                        end
                    M_ADDR:
                        word = sh;
                    M_WDATA:
                    begin
                        mem[{blk, word}] = sh;
                        word++;
                    end
                    default:
                    begin
                        sda_low = 1'b0;        // master owns the ack bit
                        word++;
                    end
                endcase
            end
            else if (bit_cnt > `EE_DATA_W)
            begin
                bit_cnt = 0;
                sda_low = 1'b0;
                if (state == M_CTRL)
                    state = rd_mode ? M_RDATA : M_ADDR;
                else if (state == M_ADDR)
                    state = M_WDATA;
                else if (state == M_RDATA && master_nack)
                    state = M_IDLE;
                if (state == M_RDATA)
                begin
                    sh      = mem[{blk, word}];
                    sda_low = !sh[7];
                end
            end
            else if (state == M_RDATA && bit_cnt > 0)
                sda_low = !sh[7-bit_cnt];      // msb first
        end
    end

endmodule

/* tb/tb_eeprom.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module tb_eeprom;
    import eeprom_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MEM_SIZE   = 1 << `EE_ADDR_W;
    localparam int RAND_PAIRS = 12;

    typedef enum {OP_WRITE, OP_READ, OP_WRITE_OVERLAP} op_e;

    logic     CLK = 1'b0;
    logic     RESET;
    logic     wr;
    logic     rd;
    ee_addr_t addr;
    ee_data_t wr_data;
    ee_data_t rd_data;
    logic     ack;
    logic     err;
    logic     busy;
    logic     model_busy;
    wire      scl;
    wire      sda;

    // stimulus table kept as one queue per column
    string    t_name [$];
    op_e      t_op [$];
    ee_addr_t t_addr [$];
    ee_data_t t_data [$];
    logic     t_busy [$];
    logic     t_err [$];
    logic     table_built = 1'b0;

    ee_data_t sb_mem [0:MEM_SIZE-1];
    ee_data_t last_rd;

    pullup (sda);
    pullup (scl);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    eeprom_master_top dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .err     (err),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model mem_model (
        .scl        (scl),
        .sda        (sda),
        .model_busy (model_busy)
    );

    function automatic ee_data_t fill_value(input ee_addr_t a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input ee_addr_t a,
                              input ee_data_t exp, input ee_data_t act);
        if (act !== exp)
            abort_run($sformatf("error %s: addr %h expected %h actual %h", name, a, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("error %s: expected %b actual %b", name, exp, act));
    endtask

    task automatic add_entry(input string name, input op_e op, input ee_addr_t a,
                             input ee_data_t d, input logic bsy, input logic e);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(a);
        t_data.push_back(d);
        t_busy.push_back(bsy);
        t_err.push_back(e);
    endtask

    task automatic build_table();
        ee_addr_t a;
        ee_data_t d;
        add_entry("basic_wr", OP_WRITE, 11'h155, 8'hA5, 1'b0, 1'b0);
        add_entry("basic_rd", OP_READ, 11'h155, 8'h00, 1'b0, 1'b0);
        for (int b = 0; b < 8; b++)
            add_entry($sformatf("block_wr_%0d", b), OP_WRITE, {3'(b), 8'h5A},
                      8'h10 + 8'(b * 17), 1'b0, 1'b0);
        for (int b = 0; b < 8; b++)
            add_entry($sformatf("block_rd_%0d", b), OP_READ, {3'(b), 8'h5A},
                      8'h00, 1'b0, 1'b0);
        add_entry("busy_setup_wr", OP_WRITE, 11'h2C3, 8'h3C, 1'b0, 1'b0);
        add_entry("busy_wr", OP_WRITE, 11'h2C3, 8'hC3, 1'b1, 1'b1);
        add_entry("busy_rd", OP_READ, 11'h2C3, 8'h00, 1'b1, 1'b1);
        add_entry("busy_check_rd", OP_READ, 11'h2C3, 8'h00, 1'b0, 1'b0);
        add_entry("overlap_wr", OP_WRITE_OVERLAP, 11'h0F0, 8'h77, 1'b0, 1'b0);
        add_entry("overlap_other_rd", OP_READ, 11'h0F1, 8'h00, 1'b0, 1'b0);
        add_entry("overlap_rd", OP_READ, 11'h0F0, 8'h00, 1'b0, 1'b0);
        for (int k = 0; k < RAND_PAIRS; k++)
        begin
            a = ee_addr_t'($urandom);
            d = ee_data_t'($urandom);
            add_entry($sformatf("rand_wr_%0d", k), OP_WRITE, a, d, 1'b0, 1'b0);
            add_entry($sformatf("rand_rd_%0d", k), OP_READ, a, 8'h00, 1'b0, 1'b0);
        end
        table_built = 1'b1;
    endtask

    task automatic run_entry(input int i);
        int       acks;
        int       settle;
        logic     err_seen;
        ee_data_t rd_seen;
        ee_data_t exp_rd;
        acks   = 0;
        settle = (t_op[i] == OP_WRITE_OVERLAP) ? 250 : 8;
        @(posedge CLK);
        model_busy <= t_busy[i];
        addr       <= t_addr[i];
        wr_data    <= t_data[i];
        wr         <= (t_op[i] != OP_READ);
        rd         <= (t_op[i] == OP_READ);
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        if (t_op[i] == OP_WRITE_OVERLAP)
        begin
            repeat (10) @(posedge CLK);
            wr      <= 1'b1;              // second request mid transfer
            addr    <= t_addr[i] ^ 11'h001;
            wr_data <= ~t_data[i];
            @(posedge CLK);
            wr <= 1'b0;
        end
        while (acks == 0)
        begin
            @(negedge CLK);
            if (ack)
            begin
                acks++;
                err_seen = err;
                rd_seen  = rd_data;
            end
        end
        repeat (settle)
        begin
            @(negedge CLK);
            if (ack)
                acks++;
        end
        check_flag({t_name[i], " single ack"}, 1'b1, acks == 1);
        check_flag({t_name[i], " busy"}, 1'b0, busy);
        check_flag({t_name[i], " err"}, t_err[i], err_seen);
        if (t_op[i] == OP_READ)
        begin
            exp_rd = t_err[i] ? last_rd : sb_mem[t_addr[i]];   // failed read keeps old byte
            check_data(t_name[i], t_addr[i], exp_rd, rd_seen);
            last_rd = exp_rd;
        end
        else if (!t_err[i])
            sb_mem[t_addr[i]] = t_data[i];
    endtask

    // about 400 clocks per table entry
    initial
    begin
        wait (table_built);
        repeat (t_name.size() * 400 + 16) @(posedge CLK);
        abort_run("timeout: a transaction did not finish with an acknowledge in time");
    end

    initial
    begin
        int seed;
        seed = 3939;
        void'($urandom(seed));
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        model_busy = 1'b0;
        for (int i = 0; i < MEM_SIZE; i++)
            sb_mem[i] = fill_value(ee_addr_t'(i));
        build_table();
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_flag("reset ack", 1'b0, ack);
        check_flag("reset err", 1'b0, err);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset scl", 1'b1, scl);
        check_flag("reset sda", 1'b1, sda);
        for (int i = 0; i < t_name.size(); i++)
            run_entry(i);
        $display("all tests passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/eeprom_pkg.sv
verilog/i2c_byte_if.sv
verilog/i2c_byte_engine.sv
verilog/eeprom_ctrl.sv
verilog/eeprom_master_top.sv
tb/eeprom_model.sv
tb/tb_eeprom.sv
